// File: common/commit_pkg.sv
`default_nettype none

package commit_pkg;

    localparam int COMMIT_WIDTH = 2;
    localparam int WB_WIDTH = 2;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_ID_WIDTH = 4;
    localparam int ROB_CNT_WIDTH = ROB_ID_WIDTH + 1; // one extra bit to tell full from empty
    localparam int PHY_REG_ID_WIDTH = 6;
    localparam int XLEN = 32;
    localparam int EXC_ID_WIDTH = 5;
    localparam int SLOT_ID_WIDTH = $clog2(COMMIT_WIDTH);
    localparam int POP_COUNT_WIDTH = SLOT_ID_WIDTH + 1;
    localparam int CSR_WRITE_PORTS = 4;

    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [ROB_CNT_WIDTH-1:0] rob_cnt_t;
    typedef logic [PHY_REG_ID_WIDTH-1:0] phy_id_t;

    // machine mode trap csrs
    typedef enum logic [11:0] {
        CSR_MTVEC  = 12'h305,
        CSR_MEPC   = 12'h341,
        CSR_MCAUSE = 12'h342,
        CSR_MTVAL  = 12'h343
    } csr_addr_e;

    typedef enum logic {
        STATE_NORMAL = 1'b0,
        STATE_FLUSH  = 1'b1
    } commit_state_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        phy_id_t new_phy_id;
        phy_id_t old_phy_id;
        logic old_phy_valid;   // no old mapping for instructions without rd
    } dispatch_t;

    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        logic has_exception;
        logic [EXC_ID_WIDTH-1:0] exception_id;
        logic [XLEN-1:0] exception_value;
    } wb_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        phy_id_t new_phy_id;
        phy_id_t old_phy_id;
        logic old_phy_valid;
        logic finish;
        logic has_exception;
        logic [EXC_ID_WIDTH-1:0] exception_id;
        logic [XLEN-1:0] exception_value;
    } rob_entry_t;

    // register freed by one retire slot
    typedef struct packed {
        logic valid;
        phy_id_t phy_id;
    } release_t;

    // mapping undone during the walk
    typedef struct packed {
        logic valid;
        phy_id_t new_phy_id;
        phy_id_t old_phy_id;
    } restore_t;

    typedef struct packed {
        logic valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } trap_info_t;

endpackage

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input wire logic clk,
    input wire logic rst,

    input wire logic alloc_en,
    input wire commit_pkg::dispatch_t alloc_entry,
    output commit_pkg::rob_id_t alloc_id,
    output logic full,

    input wire commit_pkg::wb_t [commit_pkg::WB_WIDTH-1:0] wb,
    input wire logic wb_en,

    output commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0] head_entries,
    output commit_pkg::rob_id_t [commit_pkg::COMMIT_WIDTH-1:0] head_ids,
    output logic [commit_pkg::COMMIT_WIDTH-1:0] head_valid,
    input wire logic [commit_pkg::POP_COUNT_WIDTH-1:0] head_pop_count,

    output commit_pkg::rob_entry_t tail_entry,
    output commit_pkg::rob_id_t tail_id,
    input wire logic tail_pop
);

    commit_pkg::rob_entry_t mem [commit_pkg::ROB_DEPTH];

    commit_pkg::rob_id_t head;
    commit_pkg::rob_id_t tail;
    commit_pkg::rob_cnt_t count;
    commit_pkg::rob_cnt_t count_inc;
    commit_pkg::rob_cnt_t count_dec;

    assign full = count == commit_pkg::rob_cnt_t'(commit_pkg::ROB_DEPTH);
    assign alloc_id = tail;

    // youngest entry sits just behind the tail pointer
    assign tail_id = tail - commit_pkg::rob_id_t'(1);
    assign tail_entry = mem[tail_id];

    for (genvar i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin : g_head
        assign head_ids[i] = head + commit_pkg::rob_id_t'(i);
        assign head_entries[i] = mem[head_ids[i]];
        assign head_valid[i] = count > commit_pkg::rob_cnt_t'(i);
    end

    assign count_inc = commit_pkg::rob_cnt_t'(alloc_en);
    assign count_dec = commit_pkg::rob_cnt_t'(head_pop_count) + commit_pkg::rob_cnt_t'(tail_pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + commit_pkg::rob_id_t'(head_pop_count);
            count <= count + count_inc - count_dec;
            if (alloc_en) begin
                tail <= tail + commit_pkg::rob_id_t'(1);
            end else if (tail_pop) begin
                tail <= tail_id;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            mem[tail].pc <= alloc_entry.pc;
            mem[tail].new_phy_id <= alloc_entry.new_phy_id;
            mem[tail].old_phy_id <= alloc_entry.old_phy_id;
            mem[tail].old_phy_valid <= alloc_entry.old_phy_valid;
            mem[tail].finish <= 1'b0;
            mem[tail].has_exception <= 1'b0;
        end
        if (wb_en) begin
            for (int i = 0; i < commit_pkg::WB_WIDTH; i++) begin
                if (wb[i].valid) begin
                    mem[wb[i].rob_id].finish <= 1'b1;
                    mem[wb[i].rob_id].has_exception <= wb[i].has_exception;
                    mem[wb[i].rob_id].exception_id <= wb[i].exception_id;
                    mem[wb[i].rob_id].exception_value <= wb[i].exception_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: commit/retire_select.sv
`timescale 1ns/1ps
`default_nettype none

module retire_select (
    input wire commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0] head_entries,
    input wire logic [commit_pkg::COMMIT_WIDTH-1:0] head_valid,
    input wire logic walking,

    output logic [commit_pkg::POP_COUNT_WIDTH-1:0] pop_count,
    output commit_pkg::release_t [commit_pkg::COMMIT_WIDTH-1:0] phy_release,
    output logic trap_found,
    output logic [commit_pkg::SLOT_ID_WIDTH-1:0] trap_slot
);

    logic [commit_pkg::COMMIT_WIDTH-1:0] eligible;
    logic [commit_pkg::COMMIT_WIDTH-1:0] retires;

    for (genvar i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin : g_slot
        if (i == 0) begin : g_first
            assign eligible[i] = head_valid[i] && head_entries[i].finish && !walking;
        end else begin : g_next
            // in order, only behind a clean retire
            assign eligible[i] = head_valid[i] && head_entries[i].finish && retires[i-1];
        end

        assign retires[i] = eligible[i] && !head_entries[i].has_exception;
        assign phy_release[i].valid = retires[i] && head_entries[i].old_phy_valid;
        assign phy_release[i].phy_id = head_entries[i].old_phy_id;
    end

    always_comb begin
        pop_count = '0;
        trap_found = 1'b0;
        trap_slot = '0;
        // downward scan so the oldest trapping slot wins
        for (int i = commit_pkg::COMMIT_WIDTH - 1; i >= 0; i--) begin
            if (retires[i]) begin
                pop_count = pop_count + 1'b1;
            end
            if (eligible[i] && head_entries[i].has_exception) begin
                trap_found = 1'b1;
                trap_slot = i[commit_pkg::SLOT_ID_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: commit/flush_walker.sv
`timescale 1ns/1ps
`default_nettype none

module flush_walker (
    input wire logic clk,
    input wire logic rst,

    input wire logic trap_found,
    input wire logic [commit_pkg::SLOT_ID_WIDTH-1:0] trap_slot,
    input wire commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0] head_entries,
    input wire commit_pkg::rob_id_t [commit_pkg::COMMIT_WIDTH-1:0] head_ids,

    input wire commit_pkg::rob_entry_t tail_entry,
    input wire commit_pkg::rob_id_t tail_id,

    output logic walking,
    output logic tail_pop,
    output commit_pkg::restore_t restore,
    output logic trap_commit,
    output commit_pkg::rob_entry_t trap_entry
);

    commit_pkg::commit_state_e state;
    commit_pkg::commit_state_e next_state;
    commit_pkg::rob_id_t trap_id;

    assign walking = state == commit_pkg::STATE_FLUSH;

    // one entry per cycle, youngest first
    assign tail_pop = walking;
    assign restore.valid = walking;
    assign restore.new_phy_id = tail_entry.new_phy_id;
    assign restore.old_phy_id = tail_entry.old_phy_id;

    assign trap_commit = walking && (tail_id == trap_id); // trapping entry reached

    always_comb begin
        case (state)
            commit_pkg::STATE_NORMAL: begin
                if (trap_found) begin
                    next_state = commit_pkg::STATE_FLUSH;
                end else begin
                    next_state = commit_pkg::STATE_NORMAL;
                end
            end
            commit_pkg::STATE_FLUSH: begin
                if (trap_commit) begin
                    next_state = commit_pkg::STATE_NORMAL;
                end else begin
                    next_state = commit_pkg::STATE_FLUSH;
                end
            end
            default: begin
                next_state = commit_pkg::STATE_NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= commit_pkg::STATE_NORMAL;
        end else begin
            state <= next_state;
        end
    end

    // capture trapping entry at detection
    always_ff @(posedge clk) begin
        if (!walking && trap_found) begin
            trap_entry <= head_entries[trap_slot];
            trap_id <= head_ids[trap_slot];
        end
    end

endmodule

`default_nettype wire

// File: commit/trap_csr.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr (
    input wire logic clk,
    input wire logic rst,

    input wire logic mtvec_we,
    input wire logic [commit_pkg::XLEN-1:0] mtvec_data,

    input wire logic trap_commit,
    input wire commit_pkg::rob_entry_t trap_entry,

    output commit_pkg::redirect_t redirect,
    output commit_pkg::trap_info_t trap_info
);

    logic [commit_pkg::XLEN-1:0] mtvec;
    logic [commit_pkg::XLEN-1:0] mepc;
    logic [commit_pkg::XLEN-1:0] mcause;
    logic [commit_pkg::XLEN-1:0] mtval;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else begin
            if (mtvec_we) begin
                mtvec <= mtvec_data;
            end
            // all three written together when the walk ends
            if (trap_commit) begin
                mepc <= trap_entry.pc;
                mcause <= {{(commit_pkg::XLEN - commit_pkg::EXC_ID_WIDTH){1'b0}},
                           trap_entry.exception_id};
                mtval <= trap_entry.exception_value;
            end
        end
    end

    assign redirect.valid = trap_commit;
    assign redirect.pc = mtvec;   // old mtvec if written this same cycle

    assign trap_info.mepc = mepc;
    assign trap_info.mcause = mcause;
    assign trap_info.mtval = mtval;

endmodule

`default_nettype wire

// File: rtl/commit_unit.sv
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input wire logic clk,
    input wire logic rst,

    input wire commit_pkg::dispatch_t dispatch,
    input wire logic dispatch_valid,
    output logic dispatch_ready,
    output commit_pkg::rob_id_t dispatch_id,

    input wire commit_pkg::wb_t [commit_pkg::WB_WIDTH-1:0] wb,

    input wire logic mtvec_we,
    input wire logic [commit_pkg::XLEN-1:0] mtvec_data,

    output commit_pkg::release_t [commit_pkg::COMMIT_WIDTH-1:0] phy_release,
    output commit_pkg::restore_t restore,
    output commit_pkg::redirect_t redirect,
    output commit_pkg::trap_info_t trap_info
);

    logic alloc_en;
    logic rob_full;
    logic walking;
    logic wb_en;
    logic tail_pop;
    logic trap_found;
    logic trap_commit;
    logic [commit_pkg::SLOT_ID_WIDTH-1:0] trap_slot;
    logic [commit_pkg::POP_COUNT_WIDTH-1:0] pop_count;
    logic [commit_pkg::COMMIT_WIDTH-1:0] head_valid;
    commit_pkg::rob_entry_t [commit_pkg::COMMIT_WIDTH-1:0] head_entries;
    commit_pkg::rob_id_t [commit_pkg::COMMIT_WIDTH-1:0] head_ids;
    commit_pkg::rob_entry_t tail_entry;
    commit_pkg::rob_id_t tail_id;
    commit_pkg::rob_entry_t trap_entry;

    assign dispatch_ready = !rob_full && !walking; // no dispatch during the walk
    assign alloc_en = dispatch_valid && dispatch_ready;
    assign wb_en = !walking;

    reorder_buffer reorder_buffer_i (
        .clk(clk),
        .rst(rst),
        .alloc_en(alloc_en),
        .alloc_entry(dispatch),
        .alloc_id(dispatch_id),
        .full(rob_full),
        .wb(wb),
        .wb_en(wb_en),
        .head_entries(head_entries),
        .head_ids(head_ids),
        .head_valid(head_valid),
        .head_pop_count(pop_count),
        .tail_entry(tail_entry),
        .tail_id(tail_id),
        .tail_pop(tail_pop)
    );

    retire_select retire_select_i (
        .head_entries(head_entries),
        .head_valid(head_valid),
        .walking(walking),
        .pop_count(pop_count),
        .phy_release(phy_release),
        .trap_found(trap_found),
        .trap_slot(trap_slot)
    );

    flush_walker flush_walker_i (
        .clk(clk),
        .rst(rst),
        .trap_found(trap_found),
        .trap_slot(trap_slot),
        .head_entries(head_entries),
        .head_ids(head_ids),
        .tail_entry(tail_entry),
        .tail_id(tail_id),
        .walking(walking),
        .tail_pop(tail_pop),
        .restore(restore),
        .trap_commit(trap_commit),
        .trap_entry(trap_entry)
    );

    trap_csr trap_csr_i (
        .clk(clk),
        .rst(rst),
        .mtvec_we(mtvec_we),
        .mtvec_data(mtvec_data),
        .trap_commit(trap_commit),
        .trap_entry(trap_entry),
        .redirect(redirect),
        .trap_info(trap_info)
    );

endmodule

`default_nettype wire

// File: verification/commit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module commit_checker (
    input wire logic clk,
    input wire logic rst,
    input wire commit_pkg::dispatch_t dispatch,
    input wire logic dispatch_valid,
    input wire logic dispatch_ready,
    input wire commit_pkg::rob_id_t dispatch_id,
    input wire commit_pkg::wb_t [commit_pkg::WB_WIDTH-1:0] wb,
    input wire logic mtvec_we,
    input wire logic [commit_pkg::XLEN-1:0] mtvec_data,
    input wire commit_pkg::release_t [commit_pkg::COMMIT_WIDTH-1:0] phy_release,
    input wire commit_pkg::restore_t restore,
    input wire commit_pkg::redirect_t redirect,
    input wire commit_pkg::trap_info_t trap_info,
    input wire logic case_check,
    input wire logic case_has_trap,
    input wire commit_pkg::trap_info_t case_trap,
    output logic idle,
    output int errors
);

    typedef struct packed {
        commit_pkg::rob_id_t id;
        commit_pkg::rob_entry_t e;
    } model_entry_t;

    model_entry_t q [$]; // oldest first
    model_entry_t trap_ent;
    model_entry_t ent;
    logic walking;
    logic trap_seen;
    commit_pkg::rob_id_t next_id;
    logic [commit_pkg::XLEN-1:0] mtvec;
    commit_pkg::trap_info_t exp_info;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic report(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk) begin
        int n_ret;
        logic stop;
        logic trap_now;
        logic ready_exp;
        logic rel_exp;
        if (rst) begin
            q.delete();
            walking = 1'b0;
            trap_seen = 1'b0;
            next_id = '0;
            mtvec = '0;
            exp_info = '0;
            errors = 0;
            idle = 1'b1;
        end else begin
            n_ret = 0;
            stop = 1'b0;
            trap_now = 1'b0;
            ready_exp = !walking && q.size() < commit_pkg::ROB_DEPTH;
            check_value("dispatch_ready", dispatch_ready, ready_exp);
            check_value("trap_info.mepc", trap_info.mepc, exp_info.mepc);
            check_value("trap_info.mcause", trap_info.mcause, exp_info.mcause);
            check_value("trap_info.mtval", trap_info.mtval, exp_info.mtval);

            if (case_check) begin
                if (case_has_trap != trap_seen) begin
                    report(case_has_trap ? "the expected trap did not happen"
                                         : "a trap happened in a case without one");
                end else if (case_has_trap) begin
                    check_value("trap_info.mepc", trap_info.mepc, case_trap.mepc);
                    check_value("trap_info.mcause", trap_info.mcause, case_trap.mcause);
                    check_value("trap_info.mtval", trap_info.mtval, case_trap.mtval);
                end
                trap_seen = 1'b0;
            end

            if (!walking) begin
                check_value("restore.valid", restore.valid, 1'b0);
                check_value("redirect.valid", redirect.valid, 1'b0);
                // in-order prefix, stops at the first unfinished or trapping entry
                for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
                    rel_exp = 1'b0;
                    if (!stop && i < q.size() && q[i].e.finish) begin
                        if (q[i].e.has_exception) begin
                            trap_now = 1'b1;
                            stop = 1'b1;
                        end else begin
                            rel_exp = q[i].e.old_phy_valid;
                            n_ret++;
                        end
                    end else begin
                        stop = 1'b1;
                    end
                    check_value($sformatf("release[%0d].valid", i), phy_release[i].valid, rel_exp);
                    if (rel_exp) begin
                        check_value($sformatf("release[%0d].phy_id", i), phy_release[i].phy_id,
                                    q[i].e.old_phy_id);
                    end
                end
                if (trap_now) begin
                    trap_ent = q[n_ret];
                    walking = 1'b1;
                    trap_seen = 1'b1;
                end
                repeat (n_ret) void'(q.pop_front());

                for (int w = 0; w < commit_pkg::WB_WIDTH; w++) begin
                    for (int j = 0; j < q.size(); j++) begin
                        if (wb[w].valid && q[j].id == wb[w].rob_id) begin
                            ent = q[j];
                            ent.e.finish = 1'b1;
                            ent.e.has_exception = wb[w].has_exception;
                            ent.e.exception_id = wb[w].exception_id;
                            ent.e.exception_value = wb[w].exception_value;
                            q[j] = ent;
                        end
                    end
                end

                if (dispatch_valid && ready_exp) begin
                    check_value("dispatch_id", dispatch_id, next_id);
                    ent = '0;
                    ent.id = next_id;
                    ent.e.pc = dispatch.pc;
                    ent.e.new_phy_id = dispatch.new_phy_id;
                    ent.e.old_phy_id = dispatch.old_phy_id;
                    ent.e.old_phy_valid = dispatch.old_phy_valid;
                    q.push_back(ent);
                    next_id = next_id + 1'b1;
                end
            end else begin
                for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
                    check_value($sformatf("release[%0d].valid", i), phy_release[i].valid, 1'b0);
                end
                check_value("restore.valid", restore.valid, 1'b1);
                if (q.size() == 0) begin
                    report("the walk went on past the trapping entry");
                    walking = 1'b0;
                end else begin
                    ent = q[q.size()-1]; // youngest first
                    check_value("restore.new_phy_id", restore.new_phy_id, ent.e.new_phy_id);
                    check_value("restore.old_phy_id", restore.old_phy_id, ent.e.old_phy_id);
                    void'(q.pop_back());
                    if (ent.id == trap_ent.id) begin
                        check_value("redirect.valid", redirect.valid, 1'b1);
                        check_value("redirect.pc", redirect.pc, mtvec);
                        exp_info.mepc = trap_ent.e.pc;
                        exp_info.mcause = 32'(trap_ent.e.exception_id);
                        exp_info.mtval = trap_ent.e.exception_value;
                        walking = 1'b0;
                        next_id = trap_ent.id;
                        if (q.size() != 0) begin
                            report("entries are left in the buffer after the walk");
                        end
                    end else begin
                        check_value("redirect.valid", redirect.valid, 1'b0);
                    end
                end
            end

            if (mtvec_we) begin
                mtvec = mtvec_data;
            end
            idle = q.size() == 0 && !walking;
        end
    end

endmodule

`default_nettype wire

// File: verification/commit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module commit_tb;

    localparam string CASE_FILE = "verification/commit_cases.txt";
    localparam int MAX_INSNS = commit_pkg::ROB_DEPTH;
    localparam logic [commit_pkg::XLEN-1:0] MTVEC = 32'h0000_0100;

    logic clk = 1'b0;
    logic rst = 1'b1;
    commit_pkg::dispatch_t dispatch = '0;
    logic dispatch_valid = 1'b0;
    logic dispatch_ready;
    commit_pkg::rob_id_t dispatch_id;
    commit_pkg::wb_t [commit_pkg::WB_WIDTH-1:0] wb = '0;
    logic mtvec_we = 1'b0;
    logic [commit_pkg::XLEN-1:0] mtvec_data = '0;
    commit_pkg::release_t [commit_pkg::COMMIT_WIDTH-1:0] phy_release;
    commit_pkg::restore_t restore;
    commit_pkg::redirect_t redirect;
    commit_pkg::trap_info_t trap_info;

    logic case_check = 1'b0;
    logic case_has_trap = 1'b0;
    commit_pkg::trap_info_t case_trap = '0;
    logic idle;
    int errors;
    int file_errors = 0;
    int cases_run = 0;
    int cycles = 0;
    int cycle_limit = 200;

    // instructions of the current case
    commit_pkg::dispatch_t insn [MAX_INSNS];
    commit_pkg::rob_id_t insn_id [MAX_INSNS];
    int wb_step [MAX_INSNS];
    logic insn_exc [MAX_INSNS];
    logic [commit_pkg::EXC_ID_WIDTH-1:0] insn_exc_id [MAX_INSNS];
    logic [commit_pkg::XLEN-1:0] insn_exc_val [MAX_INSNS];

    commit_unit commit_unit_i (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_id(dispatch_id),
        .wb(wb),
        .mtvec_we(mtvec_we),
        .mtvec_data(mtvec_data),
        .phy_release(phy_release),
        .restore(restore),
        .redirect(redirect),
        .trap_info(trap_info)
    );

    commit_checker commit_checker_i (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_id(dispatch_id),
        .wb(wb),
        .mtvec_we(mtvec_we),
        .mtvec_data(mtvec_data),
        .phy_release(phy_release),
        .restore(restore),
        .redirect(redirect),
        .trap_info(trap_info),
        .case_check(case_check),
        .case_has_trap(case_has_trap),
        .case_trap(case_trap),
        .idle(idle),
        .errors(errors)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic bit is_insn_row(input string line);
        byte c;
        c = line.getc(0);
        return line.len() > 1 && c != "#" && c != "C" && c != "T" && c != "N";
    endfunction

    // called on a falling edge, returns on one
    task automatic send_dispatch(input int i);
        dispatch = insn[i];
        dispatch_valid = 1'b1;
        while (!dispatch_ready) begin
            @(negedge clk);
        end
        insn_id[i] = dispatch_id; // id taken at the coming edge
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic send_writebacks(input int n, input int max_step);
        int k;
        for (int s = 0; s <= max_step; s++) begin
            k = 0;
            for (int i = 0; i < n; i++) begin
                if (wb_step[i] == s && k < commit_pkg::WB_WIDTH) begin
                    wb[k] = {1'b1, insn_id[i], insn_exc[i], insn_exc_id[i], insn_exc_val[i]};
                    k++;
                end
            end
            @(negedge clk);
            wb = '0;
        end
    endtask

    task automatic run_case(input int n, input int max_step, input logic has_trap,
                            input commit_pkg::trap_info_t expected);
        for (int i = 0; i < n; i++) begin
            send_dispatch(i);
        end
        send_writebacks(n, max_step);
        while (!idle) begin
            @(negedge clk);
        end
        case_has_trap = has_trap;
        case_trap = expected;
        case_check = 1'b1;
        @(negedge clk);
        case_check = 1'b0;
        cases_run++;
    endtask

    initial begin
        int fd;
        int rows;
        int max_step;
        int total;
        string line;
        logic [31:0] col [8];
        total = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", CASE_FILE);
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (is_insn_row(line)) begin
                    total++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * total + 200;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        mtvec_we = 1'b1;
        mtvec_data = MTVEC;
        @(negedge clk);
        mtvec_we = 1'b0;

        rows = 0;
        max_step = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if (line.getc(0) == "C") begin
                    rows = 0;
                    max_step = 0;
                end else if (line.getc(0) == "N") begin
                    run_case(rows, max_step, 1'b0, '0);
                end else if (line.getc(0) == "T") begin
                    if ($sscanf(line, "T %h %h %h", col[0], col[1], col[2]) == 3) begin
                        run_case(rows, max_step, 1'b1, {col[0], col[1], col[2]});
                    end else begin
                        $display("unreadable trap line in the case file: %s", line);
                        file_errors++;
                    end
                end else if (rows < MAX_INSNS && $sscanf(line, "%h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7]) == 8) begin
                    insn[rows] = {col[0], col[1][5:0], col[2][5:0], col[3][0]};
                    wb_step[rows] = int'(col[4]);
                    insn_exc[rows] = col[5][0];
                    insn_exc_id[rows] = col[6][commit_pkg::EXC_ID_WIDTH-1:0];
                    insn_exc_val[rows] = col[7];
                    if (wb_step[rows] > max_step) begin
                        max_step = wb_step[rows];
                    end
                    rows++;
                end else begin
                    $display("unreadable instruction line in the case file: %s", line);
                    file_errors++;
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0) begin
            $display("no case was run");
            file_errors++;
        end

        $display("errors: %0d from the checker, %0d from the case file", errors, file_errors);
        if (errors == 0 && file_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/commit_cases.txt
# C starts a case, one row per instruction in program order, all hex:
# pc new_phy old_phy old_valid wb_step has_exc exc_id exc_value; then T mepc mcause mtval, or N
C
00002000 01 21 1 3 0 00 00000000
00002004 02 22 1 2 0 00 00000000
00002008 03 23 0 1 0 00 00000000
0000200c 04 24 1 0 0 00 00000000
00002010 05 25 1 0 0 00 00000000
N
C
00003000 06 26 1 1 0 00 00000000
00003004 07 27 1 1 0 00 00000000
00003008 08 28 1 2 1 02 deadbeef
0000300c 09 29 1 0 0 00 00000000
00003010 0a 2a 0 0 0 00 00000000
T 00003008 00000002 deadbeef
C
00004000 0b 2b 1 1 0 00 00000000
00004004 0c 2c 1 1 1 0d 80000004
00004008 0d 2d 1 0 0 00 00000000
T 00004004 0000000d 80000004
C
00005000 10 30 1 3 0 00 00000000
00005004 11 31 1 3 0 00 00000000
00005008 12 32 1 1 0 00 00000000
0000500c 13 33 0 6 0 00 00000000
00005010 14 34 1 0 0 00 00000000
00005014 15 35 1 5 0 00 00000000
00005018 16 36 1 7 0 00 00000000
0000501c 17 37 0 2 0 00 00000000
00005020 18 38 1 2 0 00 00000000
00005024 19 39 1 4 0 00 00000000
00005028 1a 3a 1 0 0 00 00000000
0000502c 1b 3b 0 6 0 00 00000000
00005030 1c 3c 1 1 0 00 00000000
00005034 1d 3d 1 7 0 00 00000000
00005038 1e 3e 1 5 0 00 00000000
0000503c 1f 3f 0 4 0 00 00000000
N
C
00006000 3a 1a 1 0 1 03 00006000
T 00006000 00000003 00006000

// File: sim.f
common/commit_pkg.sv
rob/reorder_buffer.sv
commit/retire_select.sv
commit/flush_walker.sv
commit/trap_csr.sv
rtl/commit_unit.sv
verification/commit_checker.sv
verification/commit_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log && \
    verilator --binary --timing -Wno-fatal --top-module commit_tb -f sim.f -o commit_sim && \
    ./obj_dir/commit_sim > sim.log 2>&1 || \
    echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "sim passed" sim.log && exit 0 || exit 1
